// File: project.f
+incdir+design
design/id_pkg.sv
design/inst_decoder.sv
design/operand_bypass.sv
design/branch_unit.sv
design/regfile.sv
design/id_stage.sv
tests/tb_clock.sv
tests/tb_id_stage.sv

// File: run.sh
#!/bin/sh
# build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module tb_id_stage -o sim_id_stage \
    && ./obj_dir/sim_id_stage > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Regression passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

// File: tests/tb_id_stage.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module tb_id_stage;
    import id_pkg::*;

    // tests take roughly 130 cycles
    localparam int MAX_CYCLES = 400;

    // one-hot alu_op in the order add sub slt sltu and nor or xor sll srl sra lui
    localparam alu_op_t ALU_ADD = 12'h001;
    localparam alu_op_t ALU_SUB = 12'h002;
    localparam alu_op_t ALU_SLT = 12'h004;
    localparam alu_op_t ALU_AND = 12'h010;
    localparam alu_op_t ALU_SLL = 12'h100;
    localparam alu_op_t ALU_LUI = 12'h800;

    localparam logic [5:0] COND_OPS [6] = '{`OP6_BEQ, `OP6_BNE, `OP6_BLT,
                                             `OP6_BGE, `OP6_BLTU, `OP6_BGEU};
    // operand pairs are equal, negative vs positive and positive vs negative
    localparam reg_addr_t PAIR_A [3] = '{5'd20, 5'd22, 5'd23};
    localparam reg_addr_t PAIR_B [3] = '{5'd21, 5'd23, 5'd22};

    logic      clk;
    logic      resetn;
    logic      if_to_id_valid;
    if_to_id_t if_to_id;
    logic      id_allowin;
    logic      br_taken;
    word_t     br_target;
    logic      ex_allowin;
    logic      id_to_ex_valid;
    id_to_ex_t id_to_ex;
    ex_fwd_t   ex_fwd;
    rf_fwd_t   mem_fwd;
    rf_fwd_t   wb_fwd;

    word_t       rmodel [`REG_NUM];
    word_t       pc;
    word_t       va;
    word_t       vb;
    word_t       vc;
    logic [15:0] offs16;
    logic [25:0] offs26;
    logic        exp_taken;
    id_to_ex_t   held;
    int          test_errs = 0;
    int          total_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;

    tb_clock clk_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    id_stage dut_i (
        .clk            (clk),
        .resetn         (resetn),
        .if_to_id_valid (if_to_id_valid),
        .if_to_id       (if_to_id),
        .id_allowin     (id_allowin),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .ex_allowin     (ex_allowin),
        .id_to_ex_valid (id_to_ex_valid),
        .id_to_ex       (id_to_ex),
        .ex_fwd         (ex_fwd),
        .mem_fwd        (mem_fwd),
        .wb_fwd         (wb_fwd)
    );

    // instruction encoders
    function automatic word_t three_reg(input logic [4:0] op, input reg_addr_t rk,
                                        input reg_addr_t rj, input reg_addr_t rd);
        return {`OP6_ALU, 4'h0, 2'h1, op, rk, rj, rd};
    endfunction

    function automatic word_t shift_imm(input logic [4:0] op, input logic [4:0] ui5,
                                        input reg_addr_t rj, input reg_addr_t rd);
        return {`OP6_ALU, 4'h1, 2'h0, op, ui5, rj, rd};
    endfunction

    function automatic word_t reg_imm12(input logic [5:0] op6, input logic [3:0] op4,
                                        input logic [11:0] i12, input reg_addr_t rj,
                                        input reg_addr_t rd);
        return {op6, op4, i12, rj, rd};
    endfunction

    function automatic word_t reg_imm20(input logic [6:0] op7, input logic [19:0] i20,
                                        input reg_addr_t rd);
        return {op7, i20, rd};
    endfunction

    function automatic word_t branch16(input logic [5:0] op6, input logic [15:0] offs,
                                       input reg_addr_t rj, input reg_addr_t rd);
        return {op6, offs, rj, rd};
    endfunction

    // the upper ten offset bits sit in inst[9:0]
    function automatic word_t branch26(input logic [5:0] op6, input logic [25:0] offs);
        return {op6, offs[15:0], offs[25:16]};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t offset16(input logic [15:0] v);
        return {{14{v[15]}}, v, 2'b00};
    endfunction

    function automatic word_t offset26(input logic [25:0] v);
        return {{4{v[25]}}, v, 2'b00};
    endfunction

    function automatic logic cond_taken(input logic [5:0] op, input word_t a, input word_t b);
        case (op)
            `OP6_BEQ:  return a == b;
            `OP6_BNE:  return a != b;
            `OP6_BLT:  return $signed(a) < $signed(b);
            `OP6_BGE:  return $signed(a) >= $signed(b);
            `OP6_BLTU: return a < b;
            `OP6_BGEU: return a >= b;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic rf_fwd_t make_fwd(input logic we, input reg_addr_t addr, input word_t d);
        rf_fwd_t f;
        f.we   = we;
        f.addr = addr;
        f.data = d;
        return f;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic expect_flag(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_bundle(input alu_op_t op, input word_t src1, input word_t src2,
                                input logic we, input reg_addr_t dst, input logic [7:0] mem);
        expect_flag("id_to_ex_valid", id_to_ex_valid, 1'b1);
        check_word("alu_op", {20'b0, id_to_ex.alu_op}, {20'b0, op});
        check_word("alu_src1", id_to_ex.alu_src1, src1);
        check_word("alu_src2", id_to_ex.alu_src2, src2);
        expect_flag("gr_we", id_to_ex.gr_we, we);
        check_word("dest", {27'b0, id_to_ex.dest}, {27'b0, dst});
        check_word("mem_ctrl", {24'b0, id_to_ex.mem_ctrl}, {24'b0, mem});
        check_word("pc", id_to_ex.pc, pc);
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, test_errs);
            tests_failed++;
        end
        tests_run++;
        total_errs += test_errs;
        test_errs = 0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        @(negedge clk);
        wb_fwd = make_fwd(1'b1, addr, data);
        rmodel[addr] = data;
    endtask

    // hand one instruction to decode and return on the falling edge after it is taken
    task automatic issue(input word_t word, input word_t addr, input logic follow);
        @(negedge clk);
        if_to_id_valid = 1'b1;
        if_to_id.inst  = word;
        if_to_id.pc    = addr;
        #1;
        while (!id_allowin) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        // a follower lets the flush show
        if_to_id_valid = follow;
        if_to_id.inst  = three_reg(5'h00, 5'd2, 5'd1, 5'd30);
        if_to_id.pc    = addr + 32'd4;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hd2c));
        if_to_id_valid = 1'b0;
        if_to_id       = '0;
        ex_allowin     = 1'b1;
        ex_fwd         = '0;
        mem_fwd        = '0;
        wb_fwd         = '0;
        for (int i = 0; i < `REG_NUM; i++) begin
            rmodel[reg_addr_t'(i)] = '0;
        end

        @(posedge resetn);
        #1;
        expect_flag("id_to_ex_valid", id_to_ex_valid, 1'b0);
        expect_flag("br_taken", br_taken, 1'b0);
        expect_flag("id_allowin", id_allowin, 1'b1);
        end_test("reset");

        // preload through writeback with fixed branch operands
        for (int i = 1; i < `REG_NUM; i++) begin
            write_reg(reg_addr_t'(i), $urandom());
        end
        write_reg(5'd20, 32'd5);
        write_reg(5'd21, 32'd5);
        write_reg(5'd22, 32'hffff_fff0);
        write_reg(5'd23, 32'd7);
        @(negedge clk);
        wb_fwd = '0;

        pc = 32'h1c00_0000;
        issue(three_reg(5'h00, 5'd2, 5'd1, 5'd10), pc, 1'b0);
        #1;
        check_bundle(ALU_ADD, rmodel[1], rmodel[2], 1'b1, 5'd10, 8'h00);
        expect_flag("br_taken", br_taken, 1'b0);
        issue(reg_imm12(`OP6_ALU, 4'ha, 12'h800, 5'd3, 5'd11), pc, 1'b0);
        #1;
        check_bundle(ALU_ADD, rmodel[3], sext12(12'h800), 1'b1, 5'd11, 8'h00);
        issue(three_reg(5'h04, 5'd5, 5'd4, 5'd12), pc, 1'b0);
        #1;
        check_bundle(ALU_SLT, rmodel[4], rmodel[5], 1'b1, 5'd12, 8'h00);
        issue(reg_imm12(`OP6_ALU, 4'hd, 12'hf0f, 5'd6, 5'd13), pc, 1'b0);
        #1;
        check_bundle(ALU_AND, rmodel[6], 32'h0000_0f0f, 1'b1, 5'd13, 8'h00);
        // the 12-bit field holds the slli.w opcode bits above ui5
        issue(shift_imm(5'h01, 5'd9, 5'd7, 5'd14), pc, 1'b0);
        #1;
        check_bundle(ALU_SLL, rmodel[7], 32'h0000_0029, 1'b1, 5'd14, 8'h00);
        // rj overlaps the low immediate bits and names r19
        issue(reg_imm20(`OP7_LU12I, 20'habcd3, 5'd15), pc, 1'b0);
        #1;
        check_bundle(ALU_LUI, rmodel[19], 32'habcd_3000, 1'b1, 5'd15, 8'h00);
        issue(reg_imm20(`OP7_PCADDU12I, 20'h00012, 5'd16), pc, 1'b0);
        #1;
        check_bundle(ALU_ADD, pc, 32'h0001_2000, 1'b1, 5'd16, 8'h00);
        end_test("alu decode");

        // mem_ctrl is st_b st_h st_w ld_b ld_bu ld_h ld_hu ld_w
        pc = 32'h1c00_0100;
        issue(reg_imm12(`OP6_LDST, 4'h0, 12'h7fc, 5'd2, 5'd17), pc, 1'b0);
        #1;
        check_bundle(ALU_ADD, rmodel[2], sext12(12'h7fc), 1'b1, 5'd17, 8'h10);
        issue(reg_imm12(`OP6_LDST, 4'h9, 12'hffe, 5'd3, 5'd18), pc, 1'b0);
        #1;
        check_bundle(ALU_ADD, rmodel[3], sext12(12'hffe), 1'b1, 5'd18, 8'h02);
        issue(reg_imm12(`OP6_LDST, 4'h2, 12'h010, 5'd4, 5'd19), pc, 1'b0);
        #1;
        check_bundle(ALU_ADD, rmodel[4], sext12(12'h010), 1'b1, 5'd19, 8'h01);
        issue(reg_imm12(`OP6_LDST, 4'h5, 12'h802, 5'd6, 5'd5), pc, 1'b0);
        #1;
        check_bundle(ALU_ADD, rmodel[6], sext12(12'h802), 1'b0, 5'd5, 8'h40);
        check_word("store_data", id_to_ex.store_data, rmodel[5]);
        issue(reg_imm12(`OP6_LDST, 4'h6, 12'h004, 5'd8, 5'd7), pc, 1'b0);
        #1;
        check_bundle(ALU_ADD, rmodel[8], sext12(12'h004), 1'b0, 5'd7, 8'h20);
        check_word("store_data", id_to_ex.store_data, rmodel[7]);
        end_test("load/store");

        pc = 32'h1c00_0200;
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                pc = pc + 32'd4;
                offs16 = (p == 1) ? 16'h8004 : 16'h0021;
                exp_taken = cond_taken(COND_OPS[3'(k)], rmodel[PAIR_A[2'(p)]],
                                       rmodel[PAIR_B[2'(p)]]);
                issue(branch16(COND_OPS[3'(k)], offs16, PAIR_A[2'(p)], PAIR_B[2'(p)]),
                      pc, 1'b0);
                #1;
                expect_flag("br_taken", br_taken, exp_taken);
                expect_flag("id_to_ex_valid", id_to_ex_valid, 1'b1);
                if (exp_taken) begin
                    check_word("br_target", br_target, pc + offset16(offs16));
                end
            end
        end
        offs26 = 26'h3ff_fff0;
        issue(branch26(`OP6_B, offs26), pc, 1'b0);
        #1;
        expect_flag("br_taken", br_taken, 1'b1);
        check_word("br_target", br_target, pc + offset26(offs26));
        // bl with fetch still offering the next word
        offs26 = 26'h000_1234;
        issue(branch26(`OP6_BL, offs26), pc, 1'b1);
        #1;
        expect_flag("br_taken", br_taken, 1'b1);
        check_word("br_target", br_target, pc + offset26(offs26));
        check_bundle(ALU_ADD, pc, 32'd4, 1'b1, 5'd1, 8'h00);
        @(negedge clk);
        if_to_id_valid = 1'b0;
        #1;
        expect_flag("id_to_ex_valid", id_to_ex_valid, 1'b0);
        issue(branch16(`OP6_JIRL, 16'h0010, 5'd9, 5'd1), pc, 1'b0);
        #1;
        expect_flag("br_taken", br_taken, 1'b1);
        check_word("br_target", br_target, rmodel[9] + offset16(16'h0010));
        check_bundle(ALU_ADD, pc, 32'd4, 1'b1, 5'd1, 8'h00);
        // jirl still sits in the instruction register of an empty stage
        @(negedge clk);
        #1;
        expect_flag("br_taken", br_taken, 1'b0);
        expect_flag("id_to_ex_valid", id_to_ex_valid, 1'b0);
        end_test("branches");

        // add.w r24, r25, r0 held in decode by execute
        pc = 32'h1c00_0300;
        va = $urandom();
        vb = $urandom();
        vc = $urandom();
        issue(three_reg(5'h00, 5'd0, 5'd25, 5'd24), pc, 1'b0);
        ex_allowin  = 1'b0;
        ex_fwd.fwd  = make_fwd(1'b1, 5'd25, va);
        mem_fwd     = make_fwd(1'b1, 5'd25, vb);
        wb_fwd      = make_fwd(1'b1, 5'd25, vc);
        #1;
        expect_flag("id_to_ex_valid", id_to_ex_valid, 1'b1);
        check_word("alu_src1", id_to_ex.alu_src1, va);
        @(negedge clk);
        ex_fwd = '0;
        #1;
        check_word("alu_src1", id_to_ex.alu_src1, vb);
        @(negedge clk);
        mem_fwd = '0;
        // wb carries a value that r25 does not hold yet
        wb_fwd.data = ~vc;
        #1;
        check_word("alu_src1", id_to_ex.alu_src1, ~vc);
        rmodel[25] = ~vc;
        @(negedge clk);
        wb_fwd = '0;
        #1;
        check_word("alu_src1", id_to_ex.alu_src1, rmodel[25]);
        @(negedge clk);
        ex_fwd.fwd = make_fwd(1'b1, 5'd0, va);
        mem_fwd    = make_fwd(1'b1, 5'd0, vb);
        wb_fwd     = make_fwd(1'b1, 5'd0, vc);
        #1;
        check_word("alu_src2", id_to_ex.alu_src2, 32'h0);
        check_word("alu_src1", id_to_ex.alu_src1, rmodel[25]);
        @(negedge clk);
        ex_fwd     = '0;
        mem_fwd    = '0;
        wb_fwd     = '0;
        ex_allowin = 1'b1;
        end_test("bypass");

        // load in execute writing a source of add.w r26, r27, r28
        pc = 32'h1c00_0400;
        issue(three_reg(5'h00, 5'd28, 5'd27, 5'd26), pc, 1'b0);
        ex_fwd.is_load = 1'b1;
        ex_fwd.fwd     = make_fwd(1'b1, 5'd28, $urandom());
        #1;
        expect_flag("id_to_ex_valid", id_to_ex_valid, 1'b0);
        expect_flag("id_allowin", id_allowin, 1'b0);
        @(negedge clk);
        #1;
        expect_flag("id_to_ex_valid", id_to_ex_valid, 1'b0);
        expect_flag("id_allowin", id_allowin, 1'b0);
        @(negedge clk);
        ex_fwd = '0;
        #1;
        check_bundle(ALU_ADD, rmodel[27], rmodel[28], 1'b1, 5'd26, 8'h00);
        // a taken beq waits out the stall
        issue(branch16(`OP6_BEQ, 16'h0008, 5'd20, 5'd21), pc, 1'b0);
        // the forwarded value alone would still take the beq
        ex_fwd.is_load = 1'b1;
        ex_fwd.fwd     = make_fwd(1'b1, 5'd21, rmodel[20]);
        #1;
        expect_flag("br_taken", br_taken, 1'b0);
        expect_flag("id_to_ex_valid", id_to_ex_valid, 1'b0);
        @(negedge clk);
        ex_fwd = '0;
        #1;
        expect_flag("br_taken", br_taken, 1'b1);
        check_word("br_target", br_target, pc + offset16(16'h0008));
        end_test("load-use stall");

        // sub.w r29, r1, r2 under back-pressure while fetch keeps offering
        pc = 32'h1c00_0500;
        issue(three_reg(5'h02, 5'd2, 5'd1, 5'd29), pc, 1'b1);
        ex_allowin = 1'b0;
        #1;
        held = id_to_ex;
        expect_flag("id_allowin", id_allowin, 1'b0);
        check_bundle(ALU_SUB, rmodel[1], rmodel[2], 1'b1, 5'd29, 8'h00);
        @(negedge clk);
        #1;
        expect_flag("id_allowin", id_allowin, 1'b0);
        assert (id_to_ex === held) else begin
            $display("** Error id_to_ex: got %h, expected %h", id_to_ex, held);
            test_errs++;
        end
        @(negedge clk);
        if_to_id_valid = 1'b0;
        ex_allowin     = 1'b1;
        #1;
        check_bundle(ALU_SUB, rmodel[1], rmodel[2], 1'b1, 5'd29, 8'h00);
        end_test("back-pressure");

        @(negedge clk);
        $display("%0d tests run, %0d failed, %0d mismatches",
                 tests_run, tests_failed, total_errs);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset spans two rising edges and is released on a falling edge
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

// File: design/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              if_to_id_valid,
    input  id_pkg::if_to_id_t if_to_id,
    output logic              id_allowin,
    output logic              br_taken,
    output id_pkg::word_t     br_target,
    input  logic              ex_allowin,
    output logic              id_to_ex_valid,
    output id_pkg::id_to_ex_t id_to_ex,
    input  id_pkg::ex_fwd_t   ex_fwd,
    input  id_pkg::rf_fwd_t   mem_fwd,
    input  id_pkg::rf_fwd_t   wb_fwd
);
    import id_pkg::*;

    if_to_id_t id_buf;
    logic      id_valid;
    logic      ready_go;

    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    reg_addr_t dest;
    word_t     imm;
    word_t     br_offs;
    word_t     jirl_offs;
    dec_ctrl_t ctrl;

    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     rj_value;
    word_t     rkd_value;
    logic      stall;
    logic      br_raw;

    // handshake
    assign ready_go       = ~stall;
    assign id_allowin     = ~id_valid | (ready_go & ex_allowin);
    assign id_to_ex_valid = id_valid & ready_go;
    assign br_taken       = br_raw & id_valid & ~stall;

    // taken branch squashes whatever fetch hands over next
    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= if_to_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin) begin
            id_buf <= if_to_id;
        end
    end

    inst_decoder u_decoder (
        .inst      (id_buf.inst),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .dest      (dest),
        .imm       (imm),
        .br_offs   (br_offs),
        .jirl_offs (jirl_offs),
        .ctrl      (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wb_fwd)
    );

    operand_bypass u_bypass (
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .need_r1   (ctrl.need_r1),
        .need_r2   (ctrl.need_r2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    branch_unit u_branch (
        .ctrl      (ctrl),
        .pc        (id_buf.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_offs   (br_offs),
        .jirl_offs (jirl_offs),
        .taken     (br_raw),
        .target    (br_target)
    );

    // execute bundle
    assign id_to_ex.alu_op     = ctrl.alu_op;
    assign id_to_ex.alu_src1   = ctrl.src1_is_pc ? id_buf.pc : rj_value;
    assign id_to_ex.alu_src2   = ctrl.src2_is_imm ? imm : rkd_value;
    assign id_to_ex.gr_we      = ctrl.gr_we;
    assign id_to_ex.dest       = dest;
    assign id_to_ex.pc         = id_buf.pc;
    assign id_to_ex.mem_ctrl   = ctrl.mem_ctrl;
    assign id_to_ex.store_data = rkd_value;

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2,
    input  id_pkg::rf_fwd_t   wr
);
    import id_pkg::*;

    word_t regs [`REG_NUM];

    // single write port fed from writeback
    always_ff @(posedge clk) begin
        if (wr.we && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // asynchronous reads with r0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  id_pkg::dec_ctrl_t ctrl,
    input  id_pkg::word_t     pc,
    input  id_pkg::word_t     rj_value,
    input  id_pkg::word_t     rkd_value,
    input  id_pkg::word_t     br_offs,
    input  id_pkg::word_t     jirl_offs,
    output logic              taken,
    output id_pkg::word_t     target
);
    import id_pkg::*;

    logic [32:0] sub_res;
    logic        rj_eq_rd;
    logic        rj_lt_signed;
    logic        rj_lt_unsigned;
    logic        cond_met;

    // rj - rkd where a clear carry out means borrow
    assign sub_res        = {1'b0, rj_value} + {1'b0, ~rkd_value} + 33'd1;
    assign rj_eq_rd       = (sub_res[31:0] == '0);
    assign rj_lt_unsigned = ~sub_res[32];
    // differing signs decide directly and equal signs use the difference sign
    assign rj_lt_signed   = (rj_value[31] & ~rkd_value[31]) |
                            (~(rj_value[31] ^ rkd_value[31]) & sub_res[31]);

    always_comb begin
        case (ctrl.br_kind)
            BR_BEQ:  cond_met = rj_eq_rd;
            BR_BNE:  cond_met = ~rj_eq_rd;
            BR_BLT:  cond_met = rj_lt_signed;
            BR_BGE:  cond_met = ~rj_lt_signed;
            BR_BLTU: cond_met = rj_lt_unsigned;
            BR_BGEU: cond_met = ~rj_lt_unsigned;
            default: cond_met = 1'b0;
        endcase
    end

    // raw decision that the stage qualifies
    assign taken  = (ctrl.is_cond_br & cond_met) | ctrl.is_jirl | ctrl.is_direct;
    assign target = ctrl.is_jirl ? (rj_value + jirl_offs) : (pc + br_offs);

endmodule

// File: design/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    input  id_pkg::reg_addr_t rf_raddr1,
    input  id_pkg::reg_addr_t rf_raddr2,
    input  logic              need_r1,
    input  logic              need_r2,
    input  id_pkg::word_t     rf_rdata1,
    input  id_pkg::word_t     rf_rdata2,
    input  id_pkg::ex_fwd_t   ex_fwd,
    input  id_pkg::rf_fwd_t   mem_fwd,
    input  id_pkg::rf_fwd_t   wb_fwd,
    output id_pkg::word_t     rj_value,
    output id_pkg::word_t     rkd_value,
    output logic              stall
);
    import id_pkg::*;

    // r0 never matches a pending write
    function automatic logic hits(reg_addr_t raddr, rf_fwd_t w);
        return w.we && (raddr != '0) && (raddr == w.addr);
    endfunction

    // youngest producer wins
    function automatic word_t pick(reg_addr_t raddr, word_t rf_value, ex_fwd_t ex,
                                   rf_fwd_t mem, rf_fwd_t wb);
        word_t value;
        if (hits(raddr, ex.fwd)) begin
            value = ex.fwd.data;
        end else if (hits(raddr, mem)) begin
            value = mem.data;
        end else if (hits(raddr, wb)) begin
            value = wb.data;
        end else begin
            value = rf_value;
        end
        return value;
    endfunction

    logic ex_hit1;
    logic ex_hit2;

    assign rj_value  = pick(rf_raddr1, rf_rdata1, ex_fwd, mem_fwd, wb_fwd);
    assign rkd_value = pick(rf_raddr2, rf_rdata2, ex_fwd, mem_fwd, wb_fwd);

    assign ex_hit1 = need_r1 && hits(rf_raddr1, ex_fwd.fwd);
    assign ex_hit2 = need_r2 && hits(rf_raddr2, ex_fwd.fwd);

    // load data is not ready until the memory stage
    assign stall = ex_fwd.is_load && (ex_hit1 || ex_hit2);

endmodule

// File: design/inst_decoder.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module inst_decoder (
    input  id_pkg::word_t     inst,
    output id_pkg::reg_addr_t rf_raddr1,
    output id_pkg::reg_addr_t rf_raddr2,
    output id_pkg::reg_addr_t dest,
    output id_pkg::word_t     imm,
    output id_pkg::word_t     br_offs,
    output id_pkg::word_t     jirl_offs,
    output id_pkg::dec_ctrl_t ctrl
);
    import id_pkg::*;

    // opcode fields
    wire [5:0]  op_31_26 = inst[31:26];
    wire [3:0]  op_25_22 = inst[25:22];
    wire [1:0]  op_21_20 = inst[21:20];
    wire [4:0]  op_19_15 = inst[19:15];
    wire [6:0]  op_31_25 = inst[31:25];

    wire reg_addr_t rd = inst[4:0];
    wire reg_addr_t rj = inst[9:5];
    wire reg_addr_t rk = inst[14:10];

    wire [11:0] i12 = inst[21:10];
    wire [19:0] i20 = inst[24:5];
    wire [15:0] i16 = inst[25:10];
    wire [25:0] i26 = {inst[9:0], inst[25:10]};

    // three-register and shift-immediate groups
    wire is_alu  = (op_31_26 == `OP6_ALU);
    wire is_3r   = is_alu && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    wire is_shi  = is_alu && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);
    wire is_ldst = (op_31_26 == `OP6_LDST);

    wire inst_add_w  = is_3r && (op_19_15 == 5'h00);
    wire inst_sub_w  = is_3r && (op_19_15 == 5'h02);
    wire inst_slt    = is_3r && (op_19_15 == 5'h04);
    wire inst_sltu   = is_3r && (op_19_15 == 5'h05);
    wire inst_nor    = is_3r && (op_19_15 == 5'h08);
    wire inst_and    = is_3r && (op_19_15 == 5'h09);
    wire inst_or     = is_3r && (op_19_15 == 5'h0a);
    wire inst_xor    = is_3r && (op_19_15 == 5'h0b);
    wire inst_sll_w  = is_3r && (op_19_15 == 5'h0e);
    wire inst_srl_w  = is_3r && (op_19_15 == 5'h0f);
    wire inst_sra_w  = is_3r && (op_19_15 == 5'h10);

    wire inst_slli_w = is_shi && (op_19_15 == 5'h01);
    wire inst_srli_w = is_shi && (op_19_15 == 5'h09);
    wire inst_srai_w = is_shi && (op_19_15 == 5'h11);

    wire inst_slti   = is_alu && (op_25_22 == 4'h8);
    wire inst_sltui  = is_alu && (op_25_22 == 4'h9);
    wire inst_addi_w = is_alu && (op_25_22 == 4'ha);
    wire inst_andi   = is_alu && (op_25_22 == 4'hd);
    wire inst_ori    = is_alu && (op_25_22 == 4'he);
    wire inst_xori   = is_alu && (op_25_22 == 4'hf);

    wire inst_ld_b   = is_ldst && (op_25_22 == 4'h0);
    wire inst_ld_h   = is_ldst && (op_25_22 == 4'h1);
    wire inst_ld_w   = is_ldst && (op_25_22 == 4'h2);
    wire inst_st_b   = is_ldst && (op_25_22 == 4'h4);
    wire inst_st_h   = is_ldst && (op_25_22 == 4'h5);
    wire inst_st_w   = is_ldst && (op_25_22 == 4'h6);
    wire inst_ld_bu  = is_ldst && (op_25_22 == 4'h8);
    wire inst_ld_hu  = is_ldst && (op_25_22 == 4'h9);

    wire inst_jirl   = (op_31_26 == `OP6_JIRL);
    wire inst_b      = (op_31_26 == `OP6_B);
    wire inst_bl     = (op_31_26 == `OP6_BL);
    wire inst_beq    = (op_31_26 == `OP6_BEQ);
    wire inst_bne    = (op_31_26 == `OP6_BNE);
    wire inst_blt    = (op_31_26 == `OP6_BLT);
    wire inst_bge    = (op_31_26 == `OP6_BGE);
    wire inst_bltu   = (op_31_26 == `OP6_BLTU);
    wire inst_bgeu   = (op_31_26 == `OP6_BGEU);

    wire inst_lu12i_w   = (op_31_25 == `OP7_LU12I);
    wire inst_pcaddu12i = (op_31_25 == `OP7_PCADDU12I);

    // instruction classes
    wire is_load   = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    wire is_store  = inst_st_b | inst_st_h | inst_st_w;
    wire is_cond   = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    wire is_shift  = inst_slli_w | inst_srli_w | inst_srai_w;
    wire is_ui12   = inst_andi | inst_ori | inst_xori;
    wire is_si12   = inst_addi_w | inst_slti | inst_sltui | is_load | is_store;
    wire is_si20   = inst_lu12i_w | inst_pcaddu12i;
    wire src2_is_4 = inst_jirl | inst_bl;
    wire is_reg_op = is_3r & (inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor |
                              inst_and | inst_or | inst_xor | inst_sll_w | inst_srl_w |
                              inst_sra_w);

    assign imm = src2_is_4          ? word_t'(4) :
                 is_si20            ? {i20, 12'b0} :
                 (is_shift|is_si12) ? {{20{i12[11]}}, i12} :
                                      {20'b0, i12};

    assign br_offs   = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                            {{14{i16[15]}}, i16, 2'b0};
    assign jirl_offs = {{14{i16[15]}}, i16, 2'b0};

    // branches and stores compare or store rd
    assign rf_raddr1 = rj;
    assign rf_raddr2 = (is_cond | is_store) ? rd : rk;
    assign dest      = inst_bl ? reg_addr_t'(`RA_REG) : rd;

    assign ctrl.alu_op[0]  = inst_add_w | inst_addi_w | is_load | is_store |
                             inst_jirl | inst_bl | inst_pcaddu12i;
    assign ctrl.alu_op[1]  = inst_sub_w;
    assign ctrl.alu_op[2]  = inst_slt | inst_slti;
    assign ctrl.alu_op[3]  = inst_sltu | inst_sltui;
    assign ctrl.alu_op[4]  = inst_and | inst_andi;
    assign ctrl.alu_op[5]  = inst_nor;
    assign ctrl.alu_op[6]  = inst_or | inst_ori;
    assign ctrl.alu_op[7]  = inst_xor | inst_xori;
    assign ctrl.alu_op[8]  = inst_sll_w | inst_slli_w;
    assign ctrl.alu_op[9]  = inst_srl_w | inst_srli_w;
    assign ctrl.alu_op[10] = inst_sra_w | inst_srai_w;
    assign ctrl.alu_op[11] = inst_lu12i_w;

    assign ctrl.src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu12i;
    assign ctrl.src2_is_imm = is_shift | is_ui12 | is_si12 | is_si20 | src2_is_4;
    assign ctrl.need_r1     = is_reg_op | is_shift | is_ui12 | is_si12 | is_cond | inst_jirl;
    assign ctrl.need_r2     = is_reg_op | is_store | is_cond;
    assign ctrl.gr_we       = is_reg_op | is_shift | is_ui12 | inst_addi_w | inst_slti |
                              inst_sltui | is_load | is_si20 | src2_is_4;
    assign ctrl.mem_ctrl    = {inst_st_b, inst_st_h, inst_st_w,
                               inst_ld_b, inst_ld_bu, inst_ld_h, inst_ld_hu, inst_ld_w};

    assign ctrl.br_kind    = inst_bne  ? BR_BNE  :
                             inst_blt  ? BR_BLT  :
                             inst_bge  ? BR_BGE  :
                             inst_bltu ? BR_BLTU :
                             inst_bgeu ? BR_BGEU : BR_BEQ;
    assign ctrl.is_cond_br = is_cond;
    assign ctrl.is_jirl    = inst_jirl;
    assign ctrl.is_direct  = inst_b | inst_bl;

endmodule

// File: design/id_pkg.sv
`include "id_defs.svh"

package id_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    // one-hot in the order add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [`ALU_OP_W-1:0]   alu_op_t;
    typedef logic [2:0]             br_kind_t;

    // conditional branch kinds
    localparam br_kind_t BR_BEQ  = 3'd0;
    localparam br_kind_t BR_BNE  = 3'd1;
    localparam br_kind_t BR_BLT  = 3'd2;
    localparam br_kind_t BR_BGE  = 3'd3;
    localparam br_kind_t BR_BLTU = 3'd4;
    localparam br_kind_t BR_BGEU = 3'd5;

    typedef struct packed {
        logic st_b, st_h, st_w;
        logic ld_b, ld_bu, ld_h, ld_hu, ld_w;
    } mem_ctrl_t;

    typedef struct packed {
        word_t inst;
        word_t pc;
    } if_to_id_t;

    // register write seen from a later stage
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_fwd_t;

    typedef struct packed {
        logic    is_load;
        rf_fwd_t fwd;
    } ex_fwd_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_pc, src2_is_imm;
        logic      need_r1, need_r2;
        logic      gr_we;
        mem_ctrl_t mem_ctrl;
        // only meaningful with is_cond_br
        br_kind_t  br_kind;
        logic      is_cond_br, is_jirl, is_direct;
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_t   alu_op;
        word_t     alu_src1;
        word_t     alu_src2;
        logic      gr_we;
        reg_addr_t dest;
        word_t     pc;
        mem_ctrl_t mem_ctrl;
        word_t     store_data;
    } id_to_ex_t;

endpackage

// File: design/id_defs.svh
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// datapath and register file sizes
`define XLEN        32
`define REG_NUM     32
`define REG_ADDR_W  5
`define ALU_OP_W    12

// return address register written by bl
`define RA_REG      1

// major opcode in inst[31:26]
`define OP6_ALU     6'h00
`define OP6_LDST    6'h0a
`define OP6_JIRL    6'h13
`define OP6_B       6'h14
`define OP6_BL      6'h15
`define OP6_BEQ     6'h16
`define OP6_BNE     6'h17
`define OP6_BLT     6'h18
`define OP6_BGE     6'h19
`define OP6_BLTU    6'h1a
`define OP6_BGEU    6'h1b

// 20-bit immediate forms match on inst[31:25]
`define OP7_LU12I     7'h0a
`define OP7_PCADDU12I 7'h0e

`endif
